/* src/spc_pkg.sv */
// **********************************************************************
// sizes and word layout of the subroutine-return stack (SPC)
// imported by every SPC module and by the testbench checker
// **********************************************************************

package spc_pkg;

   localparam int spc_depth  = 32;   // stack entries
   localparam int spc_addr_w = 5;    // pointer and RAM address width
   localparam int spc_data_w = 19;   // full SPC word
   localparam int spc_pc_w   = 14;   // return program counter

   // return entry as pushed by a microcode call
   typedef struct packed
   {
      logic                xct_flag;  // suppress next instruction on return
      logic [3:0]          spare;     // always written as zero
      logic [spc_pc_w-1:0] pc;
   } spc_ret_t;

   // one SPC word, either a return entry or raw data
   // pushed from the M bus
   typedef union packed
   {
      spc_ret_t              ret;
      logic [spc_data_w-1:0] bits;
   } spc_word_u;

endpackage

/* src/spc_dpram.sv */
// **********************************************************************
// 32x19 dual-port RAM backing the SPC stack, both ports on clk_a
// port A is the diagnostic port and wins a write collision
// **********************************************************************

`timescale 1ns/1ps

module spc_dpram
   import spc_pkg::*;
(
   input  logic                  clk_a,
   input  logic                  reset,

   input  logic [spc_addr_w-1:0] address_a,
   input  logic [spc_data_w-1:0] data_a,
   input  logic                  wren_a,
   input  logic                  rden_a,
   output logic [spc_data_w-1:0] q_a,

   input  logic [spc_addr_w-1:0] address_b,
   input  logic [spc_data_w-1:0] data_b,
   input  logic                  wren_b,
   input  logic                  rden_b,
   output logic [spc_data_w-1:0] q_b
);

   logic [spc_data_w-1:0] mem [spc_depth];

   // one write per edge
   always_ff @(posedge clk_a)
   begin
      if (wren_a)
      begin
         mem[address_a] <= data_a;
      end
      else if (wren_b)
      begin
         mem[address_b] <= data_b;   // dropped when port A also writes
      end
   end

   // port A read, sees a port B write to the same address
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         q_a <= '0;
      end
      else if (rden_a)
      begin
         if (wren_b && address_b == address_a)
         begin
            q_a <= data_b;           // bypass
         end
         else
         begin
            q_a <= mem[address_a];
         end
      end
   end

   // port B read returns the old word on a same-address write
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         q_b <= '0;
      end
      else if (rden_b)
      begin
         q_b <= mem[address_b];
      end
   end

endmodule

/* src/spc_pointer.sv */
// **********************************************************************
// SPC stack pointer with depth count and status flags
// push moves up, pop moves down, both together leave it in place
// **********************************************************************

`timescale 1ns/1ps

module spc_pointer
   import spc_pkg::*;
(
   input  logic                  clk_a,
   input  logic                  reset,
   input  logic                  push,
   input  logic                  pop_req,

   output logic [spc_addr_w-1:0] ptr,
   output logic [spc_addr_w-1:0] wr_addr,

   output logic                  empty,
   output logic                  full,
   output logic                  overflow,
   output logic                  underflow
);

   logic [spc_addr_w:0] depth;   // 0 to 32 entries
   logic                push_only;
   logic                pop_only;

   assign push_only = push && !pop_req;
   assign pop_only  = pop_req && !push;

   // swap writes over the current top
   assign wr_addr = push_only ? ptr + 1'b1 : ptr;

   assign empty = (depth == '0);
   assign full  = (depth == (spc_addr_w + 1)'(spc_depth));

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         ptr       <= '1;   // first push lands at 0
         depth     <= '0;
         overflow  <= 1'b0;
         underflow <= 1'b0;
      end
      else
      begin
         overflow  <= 1'b0;
         underflow <= 1'b0;

         if (push_only)
         begin
            ptr <= ptr + 1'b1;
            if (full)
            begin
               overflow <= 1'b1;   // oldest entry is lost
            end
            else
            begin
               depth <= depth + 1'b1;
            end
         end
         else if (pop_only)
         begin
            ptr <= ptr - 1'b1;     // wraps even when empty
            if (empty)
            begin
               underflow <= 1'b1;
            end
            else
            begin
               depth <= depth - 1'b1;
            end
         end
      end
   end

endmodule

/* src/spc_control.sv */
// **********************************************************************
// SPC operation decoder, drives RAM port B from the stack strobes
// builds the pushed word and splits the popped word into its views
// **********************************************************************

`timescale 1ns/1ps

module spc_control
   import spc_pkg::*;
(
   input  logic                  clk_a,
   input  logic                  reset,

   input  logic                  push_ret,
   input  logic                  push_data,
   input  logic                  pop,

   input  logic [spc_pc_w-1:0]   ret_pc,
   input  logic                  ret_xct,
   input  logic [spc_data_w-1:0] m_data,

   input  logic [spc_addr_w-1:0] ptr,
   input  logic [spc_addr_w-1:0] wr_addr,

   output logic                  push,
   output logic                  pop_req,

   output logic [spc_addr_w-1:0] address_b,
   output logic [spc_data_w-1:0] data_b,
   output logic                  wren_b,
   output logic                  rden_b,
   input  logic [spc_data_w-1:0] q_b,

   output logic                  ret_valid,
   output logic [spc_data_w-1:0] spc_q,
   output logic [spc_pc_w-1:0]   ret_pc_out,
   output logic                  ret_xct_out
);

   spc_word_u wr_word;
   spc_word_u rd_word;

   // to the pointer
   assign push    = push_ret || push_data;
   assign pop_req = pop;

   // word to push, return entry takes priority
   always_comb
   begin
      wr_word.bits = m_data;
      if (push_ret)
      begin
         wr_word.ret.xct_flag = ret_xct;
         wr_word.ret.spare    = '0;
         wr_word.ret.pc       = ret_pc;
      end
   end

   // port B, a swap reads and writes the same address
   assign address_b = push ? wr_addr : ptr;
   assign data_b    = wr_word.bits;
   assign wren_b    = push;
   assign rden_b    = pop;

   // RAM read takes one edge, valid follows it
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         ret_valid <= 1'b0;
      end
      else
      begin
         ret_valid <= pop;
      end
   end

   // popped word, held until the next pop
   assign rd_word.bits = q_b;

   assign spc_q       = rd_word.bits;
   assign ret_pc_out  = rd_word.ret.pc;
   assign ret_xct_out = rd_word.ret.xct_flag;

endmodule

/* src/spc_unit.sv */
// **********************************************************************
// SPC subroutine-return stack, top level
// stack strobes go through the decoder, the diagnostic port hits RAM port A
// **********************************************************************

`timescale 1ns/1ps

module spc_unit
   import spc_pkg::*;
(
   input  logic                  clk_a,
   input  logic                  reset,

   input  logic                  push_ret,
   input  logic                  push_data,
   input  logic                  pop,

   input  logic [spc_pc_w-1:0]   ret_pc,
   input  logic                  ret_xct,
   input  logic [spc_data_w-1:0] m_data,

   input  logic [spc_addr_w-1:0] diag_addr,
   input  logic [spc_data_w-1:0] diag_wdata,
   input  logic                  diag_wren,
   input  logic                  diag_rden,

   output logic                  ret_valid,
   output logic [spc_data_w-1:0] spc_q,
   output logic [spc_pc_w-1:0]   ret_pc_out,
   output logic                  ret_xct_out,

   output logic [spc_data_w-1:0] diag_q,

   output logic                  empty,
   output logic                  full,
   output logic                  overflow,
   output logic                  underflow
);

   logic                  push;
   logic                  pop_req;
   logic [spc_addr_w-1:0] ptr;
   logic [spc_addr_w-1:0] wr_addr;
   logic [spc_addr_w-1:0] address_b;
   logic [spc_data_w-1:0] data_b;
   logic                  wren_b;
   logic                  rden_b;
   logic [spc_data_w-1:0] q_b;

   spc_control u_control
   (
      .clk_a       (clk_a),
      .reset       (reset),
      .push_ret    (push_ret),
      .push_data   (push_data),
      .pop         (pop),
      .ret_pc      (ret_pc),
      .ret_xct     (ret_xct),
      .m_data      (m_data),
      .ptr         (ptr),
      .wr_addr     (wr_addr),
      .push        (push),
      .pop_req     (pop_req),
      .address_b   (address_b),
      .data_b      (data_b),
      .wren_b      (wren_b),
      .rden_b      (rden_b),
      .q_b         (q_b),
      .ret_valid   (ret_valid),
      .spc_q       (spc_q),
      .ret_pc_out  (ret_pc_out),
      .ret_xct_out (ret_xct_out)
   );

   spc_pointer u_pointer
   (
      .clk_a     (clk_a),
      .reset     (reset),
      .push      (push),
      .pop_req   (pop_req),
      .ptr       (ptr),
      .wr_addr   (wr_addr),
      .empty     (empty),
      .full      (full),
      .overflow  (overflow),
      .underflow (underflow)
   );

   // port A belongs to the diagnostic agent
   spc_dpram u_ram
   (
      .clk_a     (clk_a),
      .reset     (reset),
      .address_a (diag_addr),
      .data_a    (diag_wdata),
      .wren_a    (diag_wren),
      .rden_a    (diag_rden),
      .q_a       (diag_q),
      .address_b (address_b),
      .data_b    (data_b),
      .wren_b    (wren_b),
      .rden_b    (rden_b),
      .q_b       (q_b)
   );

endmodule

/* dv/spc_checker.sv */
// **********************************************************************
// reference model of the SPC stack and RAM, compares the DUT outputs
// model steps on the rising edge, outputs are compared on the falling edge
// **********************************************************************

`timescale 1ns/1ps

module spc_checker
   import spc_pkg::*;
(
   input  logic                  clk_a,
   input  logic                  reset,
   input  logic                  push_ret,
   input  logic                  push_data,
   input  logic                  pop,
   input  logic [spc_pc_w-1:0]   ret_pc,
   input  logic                  ret_xct,
   input  logic [spc_data_w-1:0] m_data,
   input  logic [spc_addr_w-1:0] diag_addr,
   input  logic [spc_data_w-1:0] diag_wdata,
   input  logic                  diag_wren,
   input  logic                  diag_rden,
   input  logic                  ret_valid,
   input  logic [spc_data_w-1:0] spc_q,
   input  logic [spc_pc_w-1:0]   ret_pc_out,
   input  logic                  ret_xct_out,
   input  logic [spc_data_w-1:0] diag_q,
   input  logic                  empty,
   input  logic                  full,
   input  logic                  overflow,
   input  logic                  underflow,
   output int                    error_count
);

   logic [spc_data_w-1:0] mem [spc_depth];
   logic                  known [spc_depth];   // written since reset
   logic [spc_addr_w-1:0] ptr;
   int                    depth;
   int                    errors = 0;
   logic                  ready = 1'b0;        // set by the first reset edge
   logic                  exp_valid;
   logic                  exp_overflow;
   logic                  exp_underflow;
   logic [spc_data_w-1:0] exp_q;
   logic                  exp_q_known;
   logic [spc_data_w-1:0] exp_diag;
   logic                  exp_diag_known;

   assign error_count = errors;

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected)
      begin
         $display("Fail at %0d ns: %s expected 0x%0h, actual 0x%0h",
                  $time, name, expected, actual);
         errors++;
      end
   endtask

   always @(posedge clk_a)
   begin : model
      logic                  push;
      logic                  push_only;
      logic                  pop_only;
      logic [spc_addr_w-1:0] waddr;
      logic [spc_data_w-1:0] word;
      push      = push_ret || push_data;
      push_only = push && !pop;
      pop_only  = pop && !push;
      waddr     = push_only ? ptr + 1'b1 : ptr;
      word      = push_ret ? {ret_xct, 4'b0000, ret_pc} : m_data;   // spare bits zero
      if (reset)
      begin
         ready          = 1'b1;
         ptr            = '1;
         depth          = 0;
         exp_valid      = 1'b0;
         exp_overflow   = 1'b0;
         exp_underflow  = 1'b0;
         exp_q          = '0;
         exp_q_known    = 1'b1;
         exp_diag       = '0;
         exp_diag_known = 1'b1;
         for (int i = 0; i < spc_depth; i++)
         begin
            known[i] = 1'b0;
         end
      end
      else if (ready)
      begin
         exp_valid = pop;
         if (pop)
         begin
            exp_q       = mem[ptr];   // old top, also on a swap
            exp_q_known = known[ptr];
         end
         if (diag_rden && push && diag_addr == waddr)
         begin
            exp_diag       = word;    // bypass of the push
            exp_diag_known = 1'b1;
         end
         else if (diag_rden)
         begin
            exp_diag       = mem[diag_addr];
            exp_diag_known = known[diag_addr];
         end
         if (diag_wren)
         begin
            mem[diag_addr]   = diag_wdata;   // push is dropped
            known[diag_addr] = 1'b1;
         end
         else if (push)
         begin
            mem[waddr]   = word;
            known[waddr] = 1'b1;
         end
         exp_overflow  = push_only && depth == spc_depth;
         exp_underflow = pop_only && depth == 0;
         if (push_only)
         begin
            ptr = ptr + 1'b1;
            if (depth < spc_depth)
            begin
               depth++;
            end
         end
         else if (pop_only)
         begin
            ptr = ptr - 1'b1;
            if (depth > 0)
            begin
               depth--;
            end
         end
      end
   end

   always @(negedge clk_a)
   begin
      if (ready)
      begin
         check_value("ret_valid", 32'(exp_valid), 32'(ret_valid));
         check_value("overflow", 32'(exp_overflow), 32'(overflow));
         check_value("underflow", 32'(exp_underflow), 32'(underflow));
         check_value("empty", 32'(depth == 0), 32'(empty));
         check_value("full", 32'(depth == spc_depth), 32'(full));
         if (exp_q_known)
         begin
            check_value("spc_q", 32'(exp_q), 32'(spc_q));
            check_value("ret_pc_out", 32'(exp_q[spc_pc_w-1:0]), 32'(ret_pc_out));
            check_value("ret_xct_out", 32'(exp_q[spc_data_w-1]), 32'(ret_xct_out));
         end
         if (exp_diag_known)
         begin
            check_value("diag_q", 32'(exp_diag), 32'(diag_q));
         end
      end
   end

endmodule

/* dv/spc_properties.sv */
// **********************************************************************
// concurrent checks on the SPC top level, bound into spc_unit
// **********************************************************************

`timescale 1ns/1ps

module spc_properties
   import spc_pkg::*;
(
   input logic                  clk_a,
   input logic                  reset,
   input logic                  push_ret,
   input logic                  push_data,
   input logic                  pop,
   input logic                  ret_valid,
   input logic [spc_data_w-1:0] spc_q,
   input logic [spc_data_w-1:0] diag_q,
   input logic                  empty,
   input logic                  full,
   input logic                  overflow,
   input logic                  underflow
);

   one_push_kind: assert property (@(posedge clk_a) disable iff (reset)
      !(push_ret && push_data))
      else $error("push_ret and push_data high in the same cycle");

   valid_after_pop: assert property (@(posedge clk_a) disable iff (reset)
      ret_valid == $past(pop))
      else $error("ret_valid does not follow pop by one cycle");

   empty_not_full: assert property (@(posedge clk_a) disable iff (reset)
      !(empty && full))
      else $error("empty and full high together");

   // only a lone push onto a full stack
   overflow_cause: assert property (@(posedge clk_a) disable iff (reset)
      overflow |-> $past(full && (push_ret || push_data) && !pop))
      else $error("overflow without a push while full");

   quiet_after_reset: assert property (@(posedge clk_a)
      reset |=> (!ret_valid && !overflow && !underflow && empty && !full
                 && spc_q == '0 && diag_q == '0))
      else $error("outputs not in their reset state");

endmodule

bind spc_unit spc_properties u_properties (.*);

/* dv/spc_tb.sv */
// **********************************************************************
// testbench for the SPC stack, LFSR driven traffic in phases
// spc_checker watches the DUT and keeps the error count
// **********************************************************************

`timescale 1ns/1ps

module spc_tb
   import spc_pkg::*;
();

   logic                  clk_a;
   logic                  reset;
   logic                  push_ret;
   logic                  push_data;
   logic                  pop;
   logic [spc_pc_w-1:0]   ret_pc;
   logic                  ret_xct;
   logic [spc_data_w-1:0] m_data;
   logic [spc_addr_w-1:0] diag_addr;
   logic [spc_data_w-1:0] diag_wdata;
   logic                  diag_wren;
   logic                  diag_rden;
   logic                  ret_valid;
   logic [spc_data_w-1:0] spc_q;
   logic [spc_pc_w-1:0]   ret_pc_out;
   logic                  ret_xct_out;
   logic [spc_data_w-1:0] diag_q;
   logic                  empty;
   logic                  full;
   logic                  overflow;
   logic                  underflow;
   int                    error_count;     // kept by the checker
   int                    timeout_count;
   logic [31:0]           lfsr;
   logic [spc_addr_w-1:0] sp;              // stimulus side pointer, aims diag accesses

   spc_unit DUT (.*);

   spc_checker u_checker (.*);

   initial
   begin
      clk_a = 1'b0;
      forever #20 clk_a = ~clk_a;
   end

   // Galois form of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
   endfunction

   // one LFSR step for every bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_step(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // weights are out of 16
   task automatic drive_cycle(input int push_w, input int pop_w, input int diag_w);
      logic                  do_push;
      logic                  do_pop;
      logic                  kind;
      logic [spc_addr_w-1:0] target;
      @(posedge clk_a);
      #2;
      do_push    = take_bits(4) < push_w;
      do_pop     = take_bits(4) < pop_w;
      kind       = 1'(take_bits(1));
      push_ret   = do_push && kind;
      push_data  = do_push && !kind;
      pop        = do_pop;
      ret_pc     = spc_pc_w'(take_bits(spc_pc_w));
      ret_xct    = 1'(take_bits(1));
      m_data     = spc_data_w'(take_bits(spc_data_w));
      target     = (do_push && !do_pop) ? sp + 1'b1 : sp;   // where a push lands
      diag_rden  = take_bits(4) < diag_w;
      diag_wren  = take_bits(4) < diag_w;
      diag_addr  = (take_bits(2) == 0) ? target : spc_addr_w'(take_bits(spc_addr_w));
      diag_wdata = spc_data_w'(take_bits(spc_data_w));
      if (do_push && !do_pop)
      begin
         sp = sp + 1'b1;
      end
      else if (do_pop && !do_push)
      begin
         sp = sp - 1'b1;
      end
   endtask

   function automatic logic goal_reached(input string goal);
      if (goal == "overflow")
      begin
         return overflow;
      end
      if (goal == "underflow")
      begin
         return underflow;
      end
      if (goal == "empty")
      begin
         return empty;
      end
      return full;
   endfunction

   task automatic run_until(input string goal, input int push_w, input int pop_w,
                            input int diag_w, input int limit);
      int n;
      n = 0;
      while (!goal_reached(goal) && n < limit)
      begin
         drive_cycle(push_w, pop_w, diag_w);
         n++;
      end
      if (!goal_reached(goal))
      begin
         $display("Timeout at %0d ns: no %s after %0d cycles", $time, goal, n);
         timeout_count++;
      end
   endtask

   initial
   begin
      lfsr          = 32'hbf86_8692;
      sp            = '1;
      timeout_count = 0;
      reset         = 1'b1;
      push_ret      = 1'b0;
      push_data     = 1'b0;
      pop           = 1'b0;
      ret_pc        = '0;
      ret_xct       = 1'b0;
      m_data        = '0;
      diag_addr     = '0;
      diag_wdata    = '0;
      diag_wren     = 1'b0;
      diag_rden     = 1'b0;
      repeat (16) @(posedge clk_a);
      #2;
      reset = 1'b0;

      // plain LIFO, fill, one past full, then pop until underflow
      run_until("full", 16, 0, 0, 40);
      run_until("overflow", 16, 0, 0, 4);
      run_until("underflow", 0, 16, 0, 40);

      // biased random fill and drain with a few diag accesses
      run_until("overflow", 12, 3, 1, 600);
      run_until("underflow", 3, 12, 1, 600);

      // mixed traffic, swaps and collisions included
      repeat (2400) drive_cycle(8, 8, 4);
      run_until("empty", 0, 16, 2, 64);

      drive_cycle(0, 0, 0);
      drive_cycle(0, 0, 0);
      $display("checker errors %0d, timeouts %0d", error_count, timeout_count);
      if (error_count == 0 && timeout_count == 0)
      begin
         $display("Everything OK");
      end
      else
      begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

/* build.f */
src/spc_pkg.sv
src/spc_dpram.sv
src/spc_pointer.sv
src/spc_control.sv
src/spc_unit.sv
dv/spc_checker.sv
dv/spc_properties.sv
dv/spc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the SPC testbench with Verilator, runs it and checks the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module spc_tb -f build.f
./obj_dir/Vspc_tb | tee sim.log

if grep -q "Something failed" sim.log; then
   echo "simulation failed"
   exit 1
fi
if ! grep -q "Everything OK" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi
echo "simulation passed"
